// File: logic/l2_pkg.sv
// L2 subsystem sizes, width typedefs, op and state enums, request/response structs, counter indices
package l2_pkg;
	localparam int num_cores = 2;                                // Cores sharing the L2
	localparam int line_addr_width = 6;                          // Line address bits
	localparam int cache_index_width = 3;                        // Low address bits pick the entry
	localparam int tag_width = line_addr_width - cache_index_width; // Upper address bits
	localparam int line_bytes = 8;                               // Bytes per line
	localparam int miss_cycles = 4;                              // Refill wait on a load miss
	localparam int num_counters = 3;                             // Hit, miss, store
	localparam int num_lines = 1 << line_addr_width;             // 64 backing lines
	localparam int num_entries = 1 << cache_index_width;         // 8 cache entries

	localparam int pc_l2_hit = 0;  // Load hit count
	localparam int pc_l2_miss = 1; // Load miss count
	localparam int pc_store = 2;   // Store count

	typedef logic [line_addr_width-1:0] line_addr_t;
	typedef logic [line_bytes*8-1:0] line_data_t;
	typedef logic [line_bytes-1:0] byte_mask_t;        // One enable per byte
	typedef logic [1:0] strand_t;
	typedef logic [$clog2(num_cores)-1:0] core_id_t;
	typedef logic [31:0] counter_t;
	typedef logic [cache_index_width-1:0] cache_index_t;
	typedef logic [tag_width-1:0] cache_tag_t;
	typedef logic [$clog2(miss_cycles)-1:0] refill_count_t; // Counts down to zero

	typedef enum logic
	{
		op_load = 1'b0,
		op_store = 1'b1
	} l2_op_t;

	typedef enum logic
	{
		st_idle,   // Ready for a request
		st_refill  // Waiting on the backing line
	} cache_state_t;

	// Per-core request, 81 bits
	typedef struct packed
	{
		l2_op_t op;
		strand_t strand;
		line_addr_t address;
		line_data_t data;
		byte_mask_t mask;    // Only used by stores
	} l2_req_t;

	// Request after arbitration, 82 bits
	typedef struct packed
	{
		core_id_t core;      // Winning core
		l2_req_t req;
	} l2_arb_req_t;

	// Broadcast response, 75 bits
	typedef struct packed
	{
		core_id_t core;
		strand_t strand;
		l2_op_t op;
		logic status;        // Set on a hit
		line_addr_t address;
		line_data_t data;
	} l2_rsp_t;
endpackage

// File: logic/l2_arbiter.sv
// Alternating two-core L2 request arbiter with ready steering
`timescale 1ns/1ns

module l2_arbiter (
	input logic clk,
	input logic reset,
	input l2_pkg::l2_req_t core0_req,
	input l2_pkg::l2_req_t core1_req,
	input logic core0_valid,
	input logic core1_valid,
	input logic l2_ready,
	output logic core0_ready,
	output logic core1_ready,
	output logic arb_valid,
	output l2_pkg::l2_arb_req_t arb_req
);
	import l2_pkg::*;

	logic select_core0; // High gives core0 the slot

	// Turn flips on each ready cycle, valid or not
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			select_core0 <= 1'b0; // Core1 owns the first slot
		else if (l2_ready)
			select_core0 <= !select_core0;
	end

	// Route the selected core straight through
	always_comb
	begin
		if (select_core0)
		begin
			arb_req.core = core_id_t'(0);
			arb_req.req = core0_req;
			arb_valid = core0_valid;
		end
		else
		begin
			arb_req.core = core_id_t'(1);
			arb_req.req = core1_req;
			arb_valid = core1_valid;
		end
	end

	// Only the selected core sees ready
	assign core0_ready = select_core0 && l2_ready;
	assign core1_ready = !select_core0 && l2_ready; // Both low under back-pressure
endmodule

// File: logic/l2_cache.sv
// Direct-mapped write-through L2 cache with tag array, backing line memory and refill FSM
`timescale 1ns/1ns

module l2_cache (
	input logic clk,
	input logic reset,
	input logic arb_valid,
	input l2_pkg::l2_arb_req_t arb_req,
	output logic l2_ready,
	output logic rsp_valid,
	output logic ev_hit,
	output logic ev_miss,
	output logic ev_store,
	output l2_pkg::l2_rsp_t rsp
);
	import l2_pkg::*;

	cache_state_t state;
	refill_count_t refill_count;           // Cycles left in refill
	line_data_t backing_mem [num_lines];   // Main memory behind the cache
	line_data_t data_array [num_entries];
	cache_tag_t tag_array [num_entries];
	logic [num_entries-1:0] tag_valid;
	l2_arb_req_t req_q;                    // Request waiting on refill
	cache_index_t req_index;
	cache_tag_t req_tag;
	cache_index_t req_q_index;
	cache_tag_t req_q_tag;
	logic req_hit;
	logic is_load;
	logic accept;
	logic refill_done;
	line_data_t merged_line;               // Store data over backing line
	line_data_t fill_line;

	// Byte a*8+i of the address space at power-up
	function automatic line_data_t reset_line(line_addr_t a);
		line_data_t line;
		for (int i = 0; i < line_bytes; i++)
			line[i*8 +: 8] = 8'(a * line_bytes + i);
		return line;
	endfunction

	function automatic line_data_t merge_bytes(line_data_t old_line, line_data_t new_data,
			byte_mask_t mask);
		line_data_t merged;
		merged = old_line;
		for (int i = 0; i < line_bytes; i++)
			if (mask[i])
				merged[i*8 +: 8] = new_data[i*8 +: 8]; // Enabled bytes only
		return merged;
	endfunction

	function automatic l2_rsp_t make_rsp(l2_arb_req_t r, logic status, line_data_t data);
		l2_rsp_t p;
		p.core = r.core;
		p.strand = r.req.strand;
		p.op = r.req.op;
		p.status = status;
		p.address = r.req.address;
		p.data = data;
		return p;
	endfunction

	assign req_index = arb_req.req.address[cache_index_width-1:0];
	assign req_tag = arb_req.req.address[line_addr_width-1:cache_index_width];
	assign req_q_index = req_q.req.address[cache_index_width-1:0];
	assign req_q_tag = req_q.req.address[line_addr_width-1:cache_index_width];
	assign req_hit = tag_valid[req_index] && tag_array[req_index] == req_tag;
	assign is_load = arb_req.req.op == op_load;
	assign accept = arb_valid && l2_ready;  // Ready is only high in st_idle
	assign refill_done = state == st_refill && refill_count == '0;
	assign merged_line = merge_bytes(backing_mem[arb_req.req.address], arb_req.req.data,
		arb_req.req.mask);
	assign fill_line = backing_mem[req_q.req.address];

	// FSM, ready, valid bits and event pulses
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= st_idle;
			refill_count <= '0;
			l2_ready <= 1'b0;   // Rises one cycle after reset
			tag_valid <= '0;
			rsp_valid <= 1'b0;
			ev_hit <= 1'b0;
			ev_miss <= 1'b0;
			ev_store <= 1'b0;
		end
		else
		begin
			rsp_valid <= 1'b0;  // One-cycle strobe
			ev_hit <= accept && is_load && req_hit;
			ev_miss <= accept && is_load && !req_hit;
			ev_store <= accept && !is_load;
			case (state)
				st_idle:
				begin
					l2_ready <= 1'b1;
					if (accept)
					begin
						if (is_load && !req_hit)
						begin
							state <= st_refill;
							refill_count <= refill_count_t'(miss_cycles - 1);
							l2_ready <= 1'b0; // Low for miss_cycles cycles
						end
						else
							rsp_valid <= 1'b1; // Hit or store answers next cycle
					end
				end
				st_refill:
				begin
					if (refill_count == '0)
					begin
						state <= st_idle;
						l2_ready <= 1'b1;
						rsp_valid <= 1'b1;
						tag_valid[req_q_index] <= 1'b1;
					end
					else
						refill_count <= refill_count - 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Write-through, stores always land in memory
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int a = 0; a < num_lines; a++)
				backing_mem[a] <= reset_line(line_addr_t'(a));
		end
		else if (accept && !is_load)
			backing_mem[arb_req.req.address] <= merged_line;
	end

	// Cache lines, held request and response payload
	always_ff @(posedge clk)
	begin
		if (accept)
			req_q <= arb_req;
		if (accept && !is_load && req_hit)
			data_array[req_index] <= merged_line; // No allocate on a store miss
		if (refill_done)
		begin
			data_array[req_q_index] <= fill_line; // Evicts whatever was there
			tag_array[req_q_index] <= req_q_tag;
		end
		if (accept && !is_load)
			rsp <= make_rsp(arb_req, req_hit, merged_line);
		else if (accept && req_hit)
			rsp <= make_rsp(arb_req, 1'b1, data_array[req_index]);
		else if (refill_done)
			rsp <= make_rsp(req_q, 1'b0, fill_line);
	end
endmodule

// File: logic/perf_counters.sv
// Event counters for L2 hits, misses and stores with a select-based readout
`timescale 1ns/1ns

module perf_counters (
	input logic clk,
	input logic reset,
	input logic [l2_pkg::num_counters-1:0] events,
	input logic [1:0] pc_select,
	output l2_pkg::counter_t pc_count
);
	import l2_pkg::*;

	counter_t counts [num_counters]; // One per event line

	// Count moves the cycle after its pulse
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_counters; i++)
				counts[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < num_counters; i++)
				if (events[i])
					counts[i] <= counts[i] + 1'b1; // Wraps at 2^32
		end
	end

	// Readout mux
	always_comb
	begin
		pc_count = '0; // Out-of-range select reads zero
		for (int i = 0; i < num_counters; i++)
			if (pc_select == i)
				pc_count = counts[i];
	end
endmodule

// File: logic/gpgpu_l2_top.sv
// Shared-memory top level joining the core arbiter, L2 cache, perf counters and halt logic
`timescale 1ns/1ns

module gpgpu_l2_top (
	input logic clk,
	input logic reset,
	input logic halt0,
	input logic halt1,
	input logic core0_valid,
	input logic core1_valid,
	input l2_pkg::l2_req_t core0_req,
	input l2_pkg::l2_req_t core1_req,
	input logic [1:0] pc_select,
	output logic core0_ready,
	output logic core1_ready,
	output logic rsp_valid,
	output logic processor_halt,
	output l2_pkg::l2_rsp_t rsp,
	output l2_pkg::counter_t pc_count
);
	import l2_pkg::*;

	l2_arb_req_t arb_req;             // Arbiter to cache
	logic arb_valid;
	logic l2_ready;                   // Cache back to arbiter
	logic ev_hit;
	logic ev_miss;
	logic ev_store;
	logic [num_counters-1:0] events;  // Packed in counter index order

	// Halted only once both cores stop
	assign processor_halt = halt0 && halt1;

	assign events[pc_l2_hit] = ev_hit;
	assign events[pc_l2_miss] = ev_miss;
	assign events[pc_store] = ev_store;

	l2_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.core0_req(core0_req),
		.core1_req(core1_req),
		.core0_valid(core0_valid),
		.core1_valid(core1_valid),
		.l2_ready(l2_ready),
		.core0_ready(core0_ready),
		.core1_ready(core1_ready),
		.arb_valid(arb_valid),
		.arb_req(arb_req)
	);

	l2_cache cache (
		.clk(clk),
		.reset(reset),
		.arb_valid(arb_valid),
		.arb_req(arb_req),
		.l2_ready(l2_ready),
		.rsp_valid(rsp_valid),   // Broadcast to both cores
		.ev_hit(ev_hit),
		.ev_miss(ev_miss),
		.ev_store(ev_store),
		.rsp(rsp)
	);

	perf_counters counters (
		.clk(clk),
		.reset(reset),
		.events(events),
		.pc_select(pc_select),
		.pc_count(pc_count)
	);
endmodule

// File: verification/gpgpu_l2_assert.sv
// Concurrent checks on the L2 response strobe, refill ready gap and core ready steering
`timescale 1ns/1ns

module gpgpu_l2_assert (
	input logic clk,
	input logic reset,
	input logic l2_ready,
	input logic rsp_valid,
	input logic ev_hit,
	input logic ev_miss,
	input logic ev_store,
	input logic core0_ready,
	input logic core1_ready
);
	import l2_pkg::*;

	logic [3:0] low_run;  // Consecutive cycles with l2_ready low

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			low_run <= '0;
		else if (l2_ready)
			low_run <= '0;
		else
			low_run <= low_run + 1'b1;
	end

	// Strobe only repeats for a fresh hit or store answer
	rsp_one_cycle: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |=> (!rsp_valid || ev_hit || ev_store))
		else $error("rsp_valid stayed high without a new response");

	// Miss pulse lines up with the first low cycle and ready returns after the full gap
	miss_ready_gap: assert property (@(posedge clk) disable iff (reset)
		ev_miss |-> ##(miss_cycles) ($rose(l2_ready) && low_run == 4'(miss_cycles)))
		else $error("l2_ready was not low for exactly the refill time after a miss");

	// One ready at a time with the slot passing on after each ready cycle
	ready_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(core0_ready && core1_ready) && !(core0_ready && $past(core0_ready))
		&& !(core1_ready && $past(core1_ready)))
		else $error("core readies overlapped or one core kept ready on consecutive cycles");
endmodule

bind gpgpu_l2_top gpgpu_l2_assert checks (
	.clk(clk),
	.reset(reset),
	.l2_ready(l2_ready),
	.rsp_valid(rsp_valid),
	.ev_hit(ev_hit),
	.ev_miss(ev_miss),
	.ev_store(ev_store),
	.core0_ready(core0_ready),
	.core1_ready(core1_ready)
);

// File: verification/gpgpu_l2_tb.sv
// L2 subsystem testbench with clock, reset, stimulus replay, reference model, checks and report
`timescale 1ns/1ns

module gpgpu_l2_tb;
	import l2_pkg::*;

	localparam int max_records = 64;
	localparam logic [3:0] both_cores = 4'h2;  // Record goes to core0 and core1 together
	localparam logic [3:0] end_marker = 4'hf;

	logic clk;
	logic reset;
	logic halt0;
	logic halt1;
	logic core0_valid;
	logic core1_valid;
	l2_req_t core0_req;
	l2_req_t core1_req;
	logic [1:0] pc_select;
	logic core0_ready;
	logic core1_ready;
	logic rsp_valid;
	logic processor_halt;
	l2_rsp_t rsp;
	counter_t pc_count;

	logic [91:0] stim [max_records];      // core, op, strand, address, data, mask
	line_data_t model_mem [num_lines];    // Expected backing memory
	cache_tag_t model_tag [num_entries];
	logic [num_entries-1:0] model_valid;
	counter_t model_hits;
	counter_t model_misses;
	counter_t model_stores;
	l2_rsp_t exp_q [$];                   // Predicted responses in acceptance order
	string name_q [$];
	int accept_q [$];                     // Cycle of the accepting edge
	int low_q [$];
	bit miss_q [$];
	int cycles = 0;
	int low_cycles = 0;                   // Cycles with both core readies low
	int limit = 200;
	int num_records;
	int passes;
	int errors;
	logic [31:0] rng;

	gpgpu_l2_top uut (
		.clk(clk),
		.reset(reset),
		.halt0(halt0),
		.halt1(halt1),
		.core0_valid(core0_valid),
		.core1_valid(core1_valid),
		.core0_req(core0_req),
		.core1_req(core1_req),
		.pc_select(pc_select),
		.core0_ready(core0_ready),
		.core1_ready(core1_ready),
		.rsp_valid(rsp_valid),
		.processor_halt(processor_halt),
		.rsp(rsp),
		.pc_count(pc_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = !clk;  // 8 ns period
	end

	// Cycle count and run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles with %0d responses still outstanding",
				limit, exp_q.size());
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Back-pressure count taken mid-cycle
	always @(negedge clk)
	begin
		if (!reset && !core0_ready && !core1_ready)
			low_cycles = low_cycles + 1;  // Only happens while l2_ready is low
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Byte i of line a powers up as a*8+i
	function automatic line_data_t power_up_line(int a);
		line_data_t line;
		for (int i = 0; i < line_bytes; i++)
			line[i*8 +: 8] = 8'((a * 8 + i) % 256);
		return line;
	endfunction

	function automatic line_data_t apply_mask(line_data_t old_line, line_data_t new_data,
			byte_mask_t mask);
		line_data_t bits;
		for (int i = 0; i < line_bytes; i++)
			bits[i*8 +: 8] = {8{mask[i]}};  // Byte enable widened to bits
		return (old_line & ~bits) | (new_data & bits);
	endfunction

	task automatic check_rsp(string name, l2_rsp_t exp, l2_rsp_t act);
		if (act === exp)
		begin
			passes++;
			$display("ok    %s", name);
		end
		else
		begin
			errors++;
			$display("ERROR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(string name, counter_t exp, counter_t act);
		if (act === exp)
		begin
			passes++;
			$display("ok    %s = %0d", name, act);
		end
		else
		begin
			errors++;
			$display("ERROR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act === exp)
		begin
			passes++;
			$display("ok    %s", name);
		end
		else
		begin
			errors++;
			$display("ERROR %s expected %b actual %b", name, exp, act);
		end
	endtask

	// Model update at the accepting edge
	task automatic predict(string name, core_id_t core, l2_req_t req);
		l2_rsp_t exp;
		cache_index_t idx;
		cache_tag_t tag;
		logic hit;
		idx = req.address[cache_index_width-1:0];
		tag = req.address[line_addr_width-1:cache_index_width];
		hit = model_valid[idx] && model_tag[idx] == tag;
		if (req.op == op_store)
		begin
			model_mem[req.address] = apply_mask(model_mem[req.address], req.data, req.mask);
			model_stores++;  // Write-through with no allocate
		end
		else if (hit)
			model_hits++;
		else
		begin
			model_misses++;
			model_valid[idx] = 1'b1;  // Refill replaces the entry
			model_tag[idx] = tag;
		end
		exp.core = core;
		exp.strand = req.strand;
		exp.op = req.op;
		exp.status = hit;
		exp.address = req.address;
		exp.data = model_mem[req.address];
		exp_q.push_back(exp);
		name_q.push_back(name);
		accept_q.push_back(cycles);
		low_q.push_back(low_cycles);
		miss_q.push_back(req.op == op_load && !hit);
	endtask

	// Called on a falling edge and holds the request until its core is ready
	task automatic issue(int rec, core_id_t core, l2_req_t req);
		string name;
		name = $sformatf("rec %0d core%0d %s %02h", rec, core,
			req.op == op_store ? "store" : "load", req.address);
		if (core == 1'b0)
		begin
			core0_req = req;
			core0_valid = 1'b1;
		end
		else
		begin
			core1_req = req;
			core1_valid = 1'b1;
		end
		while (core == 1'b0 ? !core0_ready : !core1_ready)
			@(negedge clk);
		predict(name, core, req);  // Next rising edge takes it
		@(negedge clk);
		if (core == 1'b0)
			core0_valid = 1'b0;
		else
			core1_valid = 1'b0;
	endtask

	// Response checker on the broadcast bus
	always @(negedge clk)
	begin : response_monitor
		string name;
		int accepted;
		int low_before;
		bit was_miss;
		if (!reset && rsp_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Response for core%0d strand %0d arrived with nothing outstanding",
					rsp.core, rsp.strand);
			end
			else
			begin
				name = name_q.pop_front();
				accepted = accept_q.pop_front();
				low_before = low_q.pop_front();
				was_miss = miss_q.pop_front();
				check_rsp(name, exp_q.pop_front(), rsp);
				if (was_miss && low_cycles <= low_before)
				begin
					errors++;
					$display("%s missed but its response came without l2_ready going low", name);
				end
				if (!was_miss && cycles - accepted != 1)
				begin
					errors++;
					$display("%s answered %0d cycles after acceptance instead of 1",
						name, cycles - accepted);
				end
			end
		end
	end

	initial
	begin : stimulus
		l2_req_t req;
		l2_req_t alt;
		logic [3:0] target;
		reset = 1'b1;
		halt0 = 1'b0;
		halt1 = 1'b0;
		core0_valid = 1'b0;
		core1_valid = 1'b0;
		core0_req = '0;
		core1_req = '0;
		pc_select = 2'd0;
		passes = 0;
		errors = 0;
		rng = 32'd52;
		model_hits = '0;
		model_misses = '0;
		model_stores = '0;
		model_valid = '0;
		for (int a = 0; a < num_lines; a++)
			model_mem[a] = power_up_line(a);
		$readmemh("verification/l2_stimulus.txt", stim);
		num_records = 0;
		while (num_records < max_records && stim[num_records][91:88] != end_marker)
			num_records++;
		limit = 40 * num_records + 200;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < num_records; r++)
		begin
			target = stim[r][91:88];
			req.op = l2_op_t'(stim[r][84]);
			req.strand = stim[r][81:80];
			req.address = stim[r][77:72];
			req.data = stim[r][71:8];
			req.mask = stim[r][7:0];
			if (target == both_cores)
			begin
				alt = req;
				alt.strand = ~req.strand;        // Core1 twin on the next line
				alt.address = req.address + 1'b1;
				fork
					issue(r, 1'b0, req);
					issue(r, 1'b1, alt);
				join
			end
			else
				issue(r, core_id_t'(target[0]), req);
			do
				@(posedge clk);
			while (exp_q.size() != 0);
			@(negedge clk);
			rng = xorshift(rng);
			repeat (rng[1:0]) @(negedge clk);  // Idle gap of 0 to 3 cycles
		end
		repeat (2) @(negedge clk);
		pc_select = 2'd0;
		@(negedge clk);
		check_count("hit count", model_hits, pc_count);
		pc_select = 2'd1;
		@(negedge clk);
		check_count("miss count", model_misses, pc_count);
		pc_select = 2'd2;
		@(negedge clk);
		check_count("store count", model_stores, pc_count);
		pc_select = 2'd3;
		@(negedge clk);
		check_count("unused select", '0, pc_count);
		for (int h = 0; h < 4; h++)
		begin
			halt0 = h[0];
			halt1 = h[1];
			@(negedge clk);
			check_flag($sformatf("halt %b%b", halt1, halt0), h == 3, processor_halt);
		end
		$display("%0d checks passed, %0d failed", passes, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end
endmodule

// File: verification/l2_stimulus.txt
// core (0, 1, 2 both, f end) _ op (0 load, 1 store) _ strand _ line address _ data _ byte mask
// Core1 twin of a both-cores record uses the inverted strand and the next line address
0_0_1_05_0000000000000000_00
1_0_2_05_0000000000000000_00
0_0_3_0d_0000000000000000_00
1_0_0_05_0000000000000000_00
0_1_1_05_a1a2a3a4b1b2b3b4_0f
1_0_2_05_0000000000000000_00
1_1_3_22_1122334455667788_a5
0_0_0_22_0000000000000000_00
0_0_1_22_0000000000000000_00
1_0_2_0d_0000000000000000_00
1_1_0_0d_ffeeddccbbaa9988_f0
0_0_3_05_0000000000000000_00
0_1_2_3f_0123456789abcdef_ff
1_0_1_3f_0000000000000000_00
2_0_1_10_0000000000000000_00
2_0_2_10_0000000000000000_00
2_1_0_18_cafef00ddeadbeef_3c
2_0_3_18_0000000000000000_00
0_1_1_19_5555aaaa5555aaaa_00
1_0_0_19_0000000000000000_00
2_0_1_07_0000000000000000_00
2_0_2_0f_0000000000000000_00
1_0_3_07_0000000000000000_00
0_1_3_3e_9999888877776666_81
1_0_2_3e_0000000000000000_00
f_0_0_00_0000000000000000_00

// File: sources.f
logic/l2_pkg.sv
logic/l2_arbiter.sv
logic/l2_cache.sv
logic/perf_counters.sv
logic/gpgpu_l2_top.sv
verification/gpgpu_l2_assert.sv
verification/gpgpu_l2_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the L2 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module gpgpu_l2_tb -Mdir obj_dir

output=$(./obj_dir/Vgpgpu_l2_tb || true)
echo "$output"

if grep -qx "=== PASS ===" <<< "$output"; then
	exit 0
fi
exit 1
